//--- mf2_defs.svh
/*
 * Multiface Two constants: NMI and hide vectors, control and
 * snooped I/O ports, shadow store locations and RAM size
 */
`ifndef MF2_DEFS_SVH
`define MF2_DEFS_SVH

// Z80 fetch addresses
`define MF2_NMI_VECTOR      16'h0066
`define MF2_HIDE_VECTOR     16'h0065    // RET in MF2 ROM, card goes hidden

// Page in at FEE8, page out at FEEA
`define MF2_CTRL_PORT_HI    14'h3FBA

// I/O port high bytes
`define MF2_PORT_GA         8'h7F
`define MF2_PORT_CRTC_SEL   8'hBC
`define MF2_PORT_CRTC_VAL   8'hBD
`define MF2_PORT_PPI        8'hF7
`define MF2_PORT_ROMSEL     8'hDF

// Where the MF2 software expects the hardware state
`define MF2_SH_PEN          13'h1FCF
`define MF2_SH_BORDER       13'h1FDF
`define MF2_SH_COLOUR_BASE  13'h1F90    // 16 ink entries
`define MF2_SH_MODE         13'h1FEF
`define MF2_SH_BANK         13'h1FFF
`define MF2_SH_CRTC_SEL     13'h1CFF
`define MF2_SH_CRTC_BASE    13'h1DB0    // 16 CRTC registers
`define MF2_SH_PPI          13'h17FF
`define MF2_SH_ROMSEL       13'h1AAC

`define MF2_RAM_DEPTH       8192
`define MF2_IDLE_BYTE       8'hFF       // Bus is wired-AND, FF means no driver

`endif

//--- mf2_pkg.sv
/*
 * Multiface Two types shared by the bus interface and all blocks
 */
package mf2_pkg;

	// Bus widths
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;
	typedef logic [12:0] mf2_addr_t;    // 8 KB card RAM

	// Hardware register latches
	typedef logic [4:0] pen_index_t;    // Bit 4 selects border
	typedef logic [3:0] crtc_reg_t;

	// Encoding follows the old configuration bits
	typedef enum logic [1:0] {
		MF2_ENABLED  = 2'd0,
		MF2_HIDDEN   = 2'd1,
		MF2_DISABLED = 2'd2
	} mf2_mode_t;

	typedef enum logic [1:0] {
		ST_IDLE        = 2'd0,
		ST_NMI_PENDING = 2'd1,
		ST_PAGED       = 2'd2
	} mf2_state_t;

endpackage

//--- mf2_bus_if.sv
/*
 * Snooped CPU bus with the strobe edge pulses, shared by the card blocks
 */
`timescale 1ns/1ns

interface mf2_bus_if import mf2_pkg::*; ();

	cpu_addr_t cpu_addr;
	cpu_data_t cpu_dout;
	logic      mem_wr;
	logic      mem_rd;

	// One-cycle pulses
	logic io_wr_rise;
	logic m1_rise;
	logic button_rise;

	modport monitor (
		output cpu_addr, cpu_dout, mem_wr, mem_rd,
		output io_wr_rise, m1_rise, button_rise
	);

	modport sink (
		input cpu_addr, cpu_dout, mem_wr, mem_rd,
		input io_wr_rise, m1_rise, button_rise
	);

endinterface

//--- mf2_bus_monitor.sv
/*
 * Bus monitor: samples the CPU strobes and the stop button and turns
 * each into a single-cycle rising edge pulse
 */
`timescale 1ns/1ns

module mf2_bus_monitor import mf2_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_addr_t  cpu_addr,
	input  cpu_data_t  cpu_dout,
	input  logic       io_wr,
	input  logic       m1,
	input  logic       mem_wr,
	input  logic       mem_rd,
	input  logic       stop_button,
	mf2_bus_if.monitor bus
);

	logic io_wr_prev;
	logic m1_prev;
	logic button_sync;  // Button is asynchronous
	logic button_prev;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_prev  <= 1'b0;
			m1_prev     <= 1'b0;
			button_sync <= 1'b0;
			button_prev <= 1'b0;
		end else begin
			io_wr_prev  <= io_wr;
			m1_prev     <= m1;
			button_sync <= stop_button;
			button_prev <= button_sync;
		end
	end

	// Edges count once, in the first cycle the strobe is high
	assign bus.io_wr_rise  = io_wr & ~io_wr_prev;
	assign bus.m1_rise     = m1 & ~m1_prev;
	assign bus.button_rise = button_sync & ~button_prev;

	// Bus values go through as seen
	assign bus.cpu_addr = cpu_addr;
	assign bus.cpu_dout = cpu_dout;
	assign bus.mem_wr   = mem_wr;
	assign bus.mem_rd   = mem_rd;

endmodule

//--- mf2_paging_ctrl.sv
/*
 * Paging control: NMI request from the stop button, page-in on the
 * NMI fetch, hiding, control port paging and ROM/RAM select decode
 */
`timescale 1ns/1ns
`include "mf2_defs.svh"

module mf2_paging_ctrl import mf2_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  mf2_mode_t mode,
	mf2_bus_if.sink   bus,
	output logic      nmi,
	output logic      rom_en,
	output logic      ram_en
);

	mf2_state_t state;
	logic       hidden;
	logic       paged;
	logic       disabled;
	logic       ctrl_wr;    // Write to FEE8 or FEEA
	logic       nmi_fetch;
	logic       hide_fetch;

	assign disabled   = (mode == MF2_DISABLED);
	assign ctrl_wr    = bus.io_wr_rise && (bus.cpu_addr[15:2] == `MF2_CTRL_PORT_HI);
	assign nmi_fetch  = bus.m1_rise && (bus.cpu_addr == `MF2_NMI_VECTOR);
	assign hide_fetch = bus.m1_rise && (bus.cpu_addr == `MF2_HIDE_VECTOR);

	////////////////////////////////
	// Paging FSM
	////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state  <= ST_IDLE;
			hidden <= (mode != MF2_ENABLED);   // Hidden and disabled start hidden
		end else begin
			case (state)
				ST_IDLE: begin
					if (bus.button_rise && !disabled)
						state <= ST_NMI_PENDING;
					else if (ctrl_wr && !bus.cpu_addr[1] && !hidden && !disabled)
						state <= ST_PAGED;  // FEE8
				end
				ST_NMI_PENDING: begin
					// CPU took the NMI, card appears at 0000
					if (nmi_fetch) begin
						state  <= ST_PAGED;
						hidden <= 1'b0;
					end
				end
				ST_PAGED: begin
					if (ctrl_wr && bus.cpu_addr[1])
						state <= ST_IDLE;   // FEEA
					if (hide_fetch)
						hidden <= 1'b1;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	////////////////////////////////
	// Outputs
	////////////////////////////////

	assign paged = (state == ST_PAGED);
	assign nmi   = (state == ST_NMI_PENDING);

	// ROM in 0000-1FFF, RAM in 2000-3FFF
	assign rom_en = paged && (bus.cpu_addr[15:13] == 3'b000);
	assign ram_en = paged && (bus.cpu_addr[15:13] == 3'b001);

endmodule

//--- mf2_shadow_map.sv
/*
 * Shadow map: maps writes to the gate array, CRTC, PPI and ROM select
 * ports onto fixed Multiface RAM bytes
 */
`timescale 1ns/1ns
`include "mf2_defs.svh"

module mf2_shadow_map import mf2_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	mf2_bus_if.sink   bus,
	output logic      store_req,
	output mf2_addr_t store_addr
);

	pen_index_t pen_index;
	crtc_reg_t  crtc_reg;
	logic       mapped;
	logic       ga_pen_sel;
	logic       crtc_sel;

	assign ga_pen_sel = (bus.cpu_addr[15:8] == `MF2_PORT_GA) && (bus.cpu_dout[7:6] == 2'b00);
	assign crtc_sel   = (bus.cpu_addr[15:8] == `MF2_PORT_CRTC_SEL);

	// Port decode
	always_comb begin
		mapped     = 1'b1;
		store_addr = '0;
		case (bus.cpu_addr[15:8])
			`MF2_PORT_GA: begin
				// Gate array function in data bits 7:6
				case (bus.cpu_dout[7:6])
					2'b00: store_addr = `MF2_SH_PEN;
					2'b01: begin
						if (pen_index[4])
							store_addr = `MF2_SH_BORDER;
						else
							store_addr = `MF2_SH_COLOUR_BASE + {9'd0, pen_index[3:0]};
					end
					2'b10:   store_addr = `MF2_SH_MODE;
					default: store_addr = `MF2_SH_BANK;
				endcase
			end
			`MF2_PORT_CRTC_SEL: store_addr = `MF2_SH_CRTC_SEL;
			`MF2_PORT_CRTC_VAL: store_addr = `MF2_SH_CRTC_BASE + {9'd0, crtc_reg};
			`MF2_PORT_PPI:      store_addr = `MF2_SH_PPI;
			`MF2_PORT_ROMSEL:   store_addr = `MF2_SH_ROMSEL;
			default:            mapped = 1'b0;
		endcase
	end

	assign store_req = bus.io_wr_rise && mapped;

	////////////////////////////////
	// Register latches
	////////////////////////////////

	// Colour and CRTC value writes index through these
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pen_index <= '0;
			crtc_reg  <= '0;
		end else if (bus.io_wr_rise) begin
			if (ga_pen_sel)
				pen_index <= bus.cpu_dout[4:0];
			if (crtc_sel)
				crtc_reg <= bus.cpu_dout[3:0];
		end
	end

endmodule

//--- mf2_ram.sv
/*
 * Multiface 8 KB RAM: shadow stores and CPU writes, with the
 * written byte passed through to the read register
 */
`timescale 1ns/1ns
`include "mf2_defs.svh"

module mf2_ram import mf2_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      ram_en,
	input  logic      store_req,
	input  mf2_addr_t store_addr,
	mf2_bus_if.sink   bus,
	output cpu_data_t dout
);

	cpu_data_t mem [`MF2_RAM_DEPTH];

	mf2_addr_t wr_addr;
	cpu_data_t wr_data;
	logic      wr_en;
	cpu_data_t rd_data;

	////////////////////////////////
	// Access select
	////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset)
			wr_en <= 1'b0;
		else
			wr_en <= store_req | (ram_en & bus.mem_wr);
	end

	// Shadow store wins, otherwise CPU address
	always_ff @(posedge clk_sys) begin
		if (store_req)
			wr_addr <= store_addr;
		else
			wr_addr <= bus.cpu_addr[12:0];
		wr_data <= bus.cpu_dout;    // Same data source for both writers
	end

	// Memory array
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
			rd_data      <= wr_data;
		end else begin
			rd_data <= mem[wr_addr];
		end
	end

	assign dout = (ram_en && bus.mem_rd) ? rd_data : `MF2_IDLE_BYTE;

endmodule

//--- multiface_two.sv
/*
 * Multiface Two expansion on a CPC-style CPU bus
 */
`timescale 1ns/1ns

module multiface_two import mf2_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  cpu_addr_t cpu_addr,
	input  cpu_data_t cpu_dout,
	input  logic      io_wr,
	input  logic      m1,
	input  logic      mem_wr,
	input  logic      mem_rd,
	input  logic      stop_button,
	input  mf2_mode_t mode,
	output logic      nmi,
	output logic      rom_en,
	output logic      ram_en,
	output cpu_data_t dout
);

	logic      store_req;
	mf2_addr_t store_addr;

	mf2_bus_if bus ();

	mf2_bus_monitor u_bus_monitor (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cpu_addr    (cpu_addr),
		.cpu_dout    (cpu_dout),
		.io_wr       (io_wr),
		.m1          (m1),
		.mem_wr      (mem_wr),
		.mem_rd      (mem_rd),
		.stop_button (stop_button),
		.bus         (bus.monitor)
	);

	mf2_paging_ctrl u_paging_ctrl (
		.clk_sys (clk_sys),
		.reset   (reset),
		.mode    (mode),
		.bus     (bus.sink),
		.nmi     (nmi),
		.rom_en  (rom_en),
		.ram_en  (ram_en)
	);

	mf2_shadow_map u_shadow_map (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus        (bus.sink),
		.store_req  (store_req),
		.store_addr (store_addr)
	);

	mf2_ram u_ram (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ram_en     (ram_en),
		.store_req  (store_req),
		.store_addr (store_addr),
		.bus        (bus.sink),
		.dout       (dout)
	);

endmodule

//--- mf2_sva.sv
/*
 * Multiface Two NMI entry assertions, bound to the top level
 */
`timescale 1ns/1ns
`include "mf2_defs.svh"

module mf2_sva import mf2_pkg::*; (
	input logic      clk_sys,
	input logic      reset,
	input mf2_mode_t mode,
	input cpu_addr_t cpu_addr,
	input logic      m1,
	input logic      stop_button,
	input logic      nmi,
	input logic      rom_en
);

	// Synchronizer plus FSM give two cycles from the button
	nmi_from_button: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(nmi) |-> $past(stop_button, 2) && $past(mode) != MF2_DISABLED)
		else $error("nmi rose without a stop button press in an active mode");

	// Only the NMI fetch ends the request
	nmi_until_fetch: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(nmi) |-> $past(m1 && cpu_addr == `MF2_NMI_VECTOR))
		else $error("nmi fell without an M1 fetch at the NMI vector");

	page_in_on_fetch: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(nmi) && $stable(cpu_addr) |-> rom_en)    // ROM seen at the vector
		else $error("the card did not page in when nmi ended");

endmodule

//--- tb_multiface_two.sv
/*
 * Multiface Two testbench: runs the command vectors from the
 * vector file against the card and checks flags and read data
 */
`timescale 1ns/1ns

module tb_multiface_two import mf2_pkg::*; ();

	localparam int MAX_VEC = 128;

	logic      clk_sys;
	logic      reset;
	cpu_addr_t cpu_addr;
	cpu_data_t cpu_dout;
	logic      io_wr;
	logic      m1;
	logic      mem_wr;
	logic      mem_rd;
	logic      stop_button;
	mf2_mode_t mode;
	logic      nmi;
	logic      rom_en;
	logic      ram_en;
	cpu_data_t dout;

	logic [15:0] vec [0:4*MAX_VEC-1];  // cmd, addr, data, expected
	cpu_data_t   rand_bytes [256];
	int          num_vec;
	logic        loaded;
	int          checks;
	int          errors;

	multiface_two UUT (.*);

	bind multiface_two mf2_sva u_sva (.clk_sys, .reset, .mode, .cpu_addr, .m1,
		.stop_button, .nmi, .rom_en);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	//////////////////////////////
	// Bus tasks
	//////////////////////////////

	// Ends just after a rising edge, where inputs change
	task automatic step(input int n = 1);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic check_value(input string what, input logic [7:0] got,
		input logic [7:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		step(4);
		reset = 1'b0;
	endtask

	task automatic press_button();
		stop_button = 1'b1;
		step();
		stop_button = 1'b0;
		step(2);    // Synchronizer plus FSM
	endtask

	task automatic m1_fetch(input cpu_addr_t addr);
		cpu_addr = addr;
		m1       = 1'b1;
		step();
		m1 = 1'b0;
		step();
	endtask

	task automatic io_write(input cpu_addr_t addr, input cpu_data_t data);
		cpu_addr = addr;
		cpu_dout = data;
		io_wr    = 1'b1;
		step();
		io_wr = 1'b0;
		step();
	endtask

	task automatic mem_write(input cpu_addr_t addr, input cpu_data_t data);
		cpu_addr = addr;
		cpu_dout = data;
		mem_wr   = 1'b1;
		step();
		mem_wr = 1'b0;
		step();
	endtask

	task automatic mem_read(input cpu_addr_t addr, output cpu_data_t data);
		cpu_addr = addr;
		mem_rd   = 1'b1;
		step(3);
		data   = dout;
		mem_rd = 1'b0;
	endtask

	// Random bytes written in a block, then read back
	task automatic random_test(input cpu_addr_t base, input int count);
		cpu_data_t got;
		for (int i = 0; i < count; i++) begin
			rand_bytes[i] = cpu_data_t'($urandom);
			mem_write(cpu_addr_t'(base + i), rand_bytes[i]);
		end
		for (int i = 0; i < count; i++) begin
			mem_read(cpu_addr_t'(base + i), got);
			check_value($sformatf("readback %h", base + i), got, rand_bytes[i]);
		end
	endtask

	//////////////////////////////
	// Vector run
	//////////////////////////////

	initial begin
		cpu_data_t   got;
		logic [15:0] cmd;
		logic [15:0] addr;
		logic [15:0] data;
		logic [15:0] exp;
		reset       = 1'b1;
		cpu_addr    = '0;
		cpu_dout    = '0;
		io_wr       = 1'b0;
		m1          = 1'b0;
		mem_wr      = 1'b0;
		mem_rd      = 1'b0;
		stop_button = 1'b0;
		mode        = MF2_ENABLED;
		checks      = 0;
		errors      = 0;
		num_vec     = 0;
		loaded      = 1'b0;
		void'($urandom(14414));
		for (int i = 0; i < 4 * MAX_VEC; i++)
			vec[i] = 16'hFFFF;  // Reads as end marker
		$readmemh("mf2_vectors.txt", vec);
		while (num_vec < MAX_VEC && vec[4*num_vec][3:0] != 4'hF)
			num_vec++;
		loaded = 1'b1;
		if (num_vec == 0) begin
			$display("The vector file is missing or holds no commands");
			errors++;
		end
		apply_reset();
		for (int i = 0; i < num_vec; i++) begin
			cmd  = vec[4*i];
			addr = vec[4*i+1];
			data = vec[4*i+2];
			exp  = vec[4*i+3];
			case (cmd[3:0])
				4'h0: mode = mf2_mode_t'(data[1:0]);
				4'h1: apply_reset();
				4'h2: press_button();
				4'h3: m1_fetch(addr);
				4'h4: io_write(addr, data[7:0]);
				4'h5: mem_write(addr, data[7:0]);
				4'h6: begin
					mem_read(addr, got);
					check_value($sformatf("read %h", addr), got, exp[7:0]);
				end
				4'h7: begin
					cpu_addr = addr;
					step();
					check_value($sformatf("flags at %h", addr), {5'd0, nmi, rom_en, ram_en},
						exp[7:0]);
				end
				4'h8: random_test(addr, int'(data));
				default: begin
					$display("Vector %0d has an unknown command %h", i, cmd);
					errors++;
				end
			endcase
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// Watchdog allows 20 cycles per vector plus margin
	initial begin
		wait (loaded);
		repeat ((num_vec + 10) * 20) @(posedge clk_sys);
		$display("Timeout: the vectors did not finish in %0d cycles", (num_vec + 10) * 20);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- mf2_vectors.txt
// cmd addr data expected, hex. cmd 0 mode, 1 reset, 2 button, 3 M1, 4 I/O wr,
// 5 mem wr, 6 mem rd, 7 flags {nmi,rom_en,ram_en}, 8 random RAM block, F end
0 0000 00 00
1 0000 00 00
7 1000 00 00
6 2800 00 FF
2 0000 00 00
7 1000 00 04
3 0066 00 00
7 1000 00 02
7 2800 00 01
7 4000 00 00
8 2000 10 00
8 3FF0 10 00
5 2123 5A 00
6 2123 00 5A
6 0123 00 FF
6 4123 00 FF
4 7F00 03 00
4 7F00 4B 00
4 BC00 06 00
4 BD00 19 00
4 F700 82 00
4 DF00 07 00
6 3FCF 00 03
6 3F93 00 4B
6 3CFF 00 06
6 3DB6 00 19
6 37FF 00 82
6 3AAC 00 07
4 FEEA 00 00
7 1000 00 00
4 FEE8 00 00
7 1000 00 02
3 0065 00 00
4 FEEA 00 00
4 FEE8 00 00
7 1000 00 00
0 0000 01 00
1 0000 00 00
4 FEE8 00 00
7 1000 00 00
2 0000 00 00
7 1000 00 04
3 0066 00 00
7 1000 00 02
4 FEEA 00 00
4 FEE8 00 00
7 1000 00 02
0 0000 02 00
1 0000 00 00
2 0000 00 00
7 1000 00 00
F 0000 00 00

//--- sim.f
+incdir+.
mf2_pkg.sv
mf2_bus_if.sv
mf2_bus_monitor.sv
mf2_paging_ctrl.sv
mf2_shadow_map.sv
mf2_ram.sv
multiface_two.sv
mf2_sva.sv
tb_multiface_two.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the Multiface Two testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_multiface_two -f sim.f || exit 1
result=$(./obj_dir/Vtb_multiface_two)
echo "$result"
echo "$result" | grep -qx "NO ERRORS" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
